/* Bender.yml */
package:
  name: proc

sources:
  - src/procPkg.sv
  - src/fetchStage.sv
  - src/decodeStage.sv
  - src/executeStage.sv
  - src/memoryStage.sv
  - src/apbHost.sv
  - src/proc.sv
  - target: test
    files:
      - verification/procTb.sv

/* proc.f */
src/procPkg.sv
src/fetchStage.sv
src/decodeStage.sv
src/executeStage.sv
src/memoryStage.sv
src/apbHost.sv
src/proc.sv
verification/procTb.sv

/* src/apbHost.sv */
module apbHost (
   input  logic clk,
   input  logic rstN,
   input  logic [11:0] paddr,
   input  logic psel,
   input  logic penable,
   input  logic pwrite,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata,
   output logic pready,
   output logic pslverr,
   input  procPkg::memWbT memWb,
   input  logic [procPkg::dataWidth-1:0] hostRdata,
   output procPkg::hostReqT host,
   output logic run,
   output logic start
);
   import procPkg::*;

   logic running;
   logic halted;
   logic errFlag;
   logic startPulse;
   logic access;
   logic inImem;
   logic inDmem;
   logic isCtrl;
   logic isStatus;

   assign access = psel && penable;
   assign inImem = paddr[11:10] == imemBase[11:10];
   assign inDmem = paddr[11:10] == dmemBase[11:10];
   assign isCtrl = paddr == ctrlAddr;
   assign isStatus = paddr == statusAddr;

   // memory windows are closed while the core runs
   assign pslverr = access && (((inImem || inDmem) && running) ||
                               !(inImem || inDmem || isCtrl || isStatus));
   assign pready = 1'b1;

   always_comb begin
      host.addr = paddr[addrWidth+1:2];
      host.wdata = pwdata[dataWidth-1:0];
      host.imemWe = access && pwrite && inImem && !running;
      host.dmemWe = access && pwrite && inDmem && !running;
   end

   // imem window is write only and reads back as zero
   always_comb begin
      prdata = '0;
      if (isStatus) begin
         prdata[2:0] = {errFlag, halted, running};
      end else if (inDmem && !running) begin
         prdata[dataWidth-1:0] = hostRdata;
      end
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         running <= 1'b0;
         halted <= 1'b0;
         errFlag <= 1'b0;
         startPulse <= 1'b0;
      end else begin
         startPulse <= 1'b0;
         if (running && memWb.valid && memWb.halt) begin
            running <= 1'b0;
            halted <= 1'b1;
            errFlag <= memWb.err;
         end else if (!running && access && pwrite && isCtrl && pwdata[0]) begin
            running <= 1'b1;
            halted <= 1'b0;
            errFlag <= 1'b0;
            startPulse <= 1'b1;
         end
      end
   end

   assign run = running;
   assign start = startPulse;

   assert property (@(posedge clk) disable iff (!rstN)
      psel && penable |-> $past(psel && !penable));

endmodule

/* src/decodeStage.sv */
module decodeStage (
   input  logic clk,
   input  logic rstN,
   input  logic run,
   input  procPkg::ifIdT ifId,
   input  procPkg::memWbT memWb,
   input  logic flush,
   output logic stall,
   output procPkg::idExT idEx
);
   import procPkg::*;

   logic [dataWidth-1:0] regs [1 << regAddrWidth];
   opcodeT op;
   logic signed [5:0] imm6;
   logic signed [8:0] imm9;
   logic useA;
   logic useB;
   logic wbHit;
   idExT dec;

   assign op = ifId.instr.rType.opcode;
   assign imm6 = ifId.instr.iType.imm;
   assign imm9 = ifId.instr.lType.imm;
   assign wbHit = memWb.valid && memWb.regWrite;

   always_comb begin
      dec = '0;
      dec.valid = ifId.valid;
      dec.op = op;
      dec.pc = ifId.pc;
      dec.rd = ifId.instr.rType.rd;
      dec.rs = ifId.instr.rType.rs;
      dec.rt = ifId.instr.rType.rt;
      useA = 1'b0;
      useB = 1'b0;
      case (op)
         opAdd, opSub, opAnd, opXor: begin
            dec.regWrite = 1'b1;
            useA = 1'b1;
            useB = 1'b1;
         end
         opAddi, opLd: begin
            dec.regWrite = 1'b1;
            dec.memRead = (op == opLd);
            dec.imm = {{(dataWidth - 6){imm6[5]}}, imm6};
            useA = 1'b1;
         end
         opSt: begin
            // store data sits in rd, it travels as the second operand
            dec.rt = ifId.instr.iType.rd;
            dec.memWrite = 1'b1;
            dec.imm = {{(dataWidth - 6){imm6[5]}}, imm6};
            useA = 1'b1;
            useB = 1'b1;
         end
         opLbi: begin
            dec.regWrite = 1'b1;
            dec.imm = {{(dataWidth - 9){imm9[8]}}, imm9};
         end
         opBeqz: begin
            dec.rt = ifId.instr.lType.rd;
            dec.branch = 1'b1;
            dec.imm = {{(dataWidth - 9){imm9[8]}}, imm9};
            useB = 1'b1;
         end
         // HALT and every undefined opcode stop the core at writeback
         default: dec.halt = 1'b1;
      endcase
      // writeback lands in the same cycle, take its value directly
      dec.srcA = (wbHit && memWb.rd == dec.rs) ? memWb.wbData : regs[dec.rs];
      dec.srcB = (wbHit && memWb.rd == dec.rt) ? memWb.wbData : regs[dec.rt];
   end

   // load in execute whose result this instruction needs right away
   assign stall = ifId.valid && idEx.valid && idEx.memRead &&
                  ((useA && idEx.rd == dec.rs) || (useB && idEx.rd == dec.rt));

   always_ff @(posedge clk) begin
      if (wbHit) begin
         regs[memWb.rd] <= memWb.wbData;
      end
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         idEx <= '0;
      end else if (!run || flush || stall) begin
         idEx <= '0;
      end else begin
         idEx <= dec;
      end
   end

   assert property (@(posedge clk) disable iff (!rstN) !(idEx.memRead && idEx.memWrite));

endmodule

/* src/executeStage.sv */
module executeStage (
   input  logic clk,
   input  logic rstN,
   input  logic run,
   input  procPkg::idExT idEx,
   output procPkg::exMemT exMem,
   input  procPkg::memWbT memWb,
   output logic redirect,
   output logic [procPkg::addrWidth-1:0] target
);
   import procPkg::*;

   logic [dataWidth-1:0] opA;
   logic [dataWidth-1:0] opB;
   logic [dataWidth-1:0] result;
   exMemT nxt;

   // youngest producer wins, so memory is checked after writeback
   function automatic logic [dataWidth-1:0] forward(
      input logic [regAddrWidth-1:0] r,
      input logic [dataWidth-1:0] regVal,
      input exMemT m,
      input memWbT w
   );
      logic [dataWidth-1:0] v;
      v = regVal;
      if (w.valid && w.regWrite && w.rd == r) begin
         v = w.wbData;
      end
      if (m.valid && m.regWrite && !m.memRead && m.rd == r) begin
         v = m.result;
      end
      return v;
   endfunction

   assign opA = forward(idEx.rs, idEx.srcA, exMem, memWb);
   assign opB = forward(idEx.rt, idEx.srcB, exMem, memWb);

   always_comb begin
      case (idEx.op)
         opAdd: result = opA + opB;
         opSub: result = opA - opB;
         opAnd: result = opA & opB;
         opXor: result = opA ^ opB;
         opAddi, opLd, opSt: result = opA + idEx.imm;
         opLbi: result = idEx.imm;
         // halting instructions carry their error flag in bit 0
         default: result = dataWidth'(idEx.op != opHalt);
      endcase
   end

   assign redirect = run && idEx.valid && idEx.branch && opB == '0;
   assign target = idEx.pc + 1'b1 + idEx.imm[addrWidth-1:0];

   always_comb begin
      nxt.valid = run && idEx.valid;
      nxt.rd = idEx.rd;
      nxt.result = result;
      nxt.storeData = opB;
      nxt.regWrite = idEx.regWrite;
      nxt.memRead = idEx.memRead;
      nxt.memWrite = idEx.memWrite;
      nxt.halt = idEx.halt;
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         exMem <= '0;
      end else begin
         exMem <= nxt;
      end
   end

   // a taken branch must also empty decode on the following cycle
   assert property (@(posedge clk) disable iff (!rstN) redirect |=> !idEx.valid);

endmodule

/* src/fetchStage.sv */
module fetchStage (
   input  logic clk,
   input  logic rstN,
   input  logic run,
   input  logic start,
   input  procPkg::hostReqT host,
   input  logic stall,
   input  logic redirect,
   input  logic [procPkg::addrWidth-1:0] target,
   output procPkg::ifIdT ifId
);
   import procPkg::*;

   logic [dataWidth-1:0] imem [memDepth];
   logic [addrWidth-1:0] pc;

   // program load from the host, only possible while idle
   always_ff @(posedge clk) begin
      if (host.imemWe) begin
         imem[host.addr] <= host.wdata;
      end
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pc <= '0;
         ifId <= '0;
      end else if (start) begin
         pc <= '0;
         ifId.valid <= 1'b0;
      end else if (!run) begin
         ifId.valid <= 1'b0;
      end else if (redirect) begin
         // taken branch, the word fetched this cycle is dropped
         pc <= target;
         ifId.valid <= 1'b0;
      end else if (!stall) begin
         pc <= pc + 1'b1;
         ifId.valid <= 1'b1;
         ifId.pc <= pc;
         ifId.instr <= imem[pc];
      end
   end

   // a run begins with an empty pipeline, so nothing can branch yet
   assert property (@(posedge clk) disable iff (!rstN) start |-> !redirect);

endmodule

/* src/memoryStage.sv */
module memoryStage (
   input  logic clk,
   input  logic rstN,
   input  logic run,
   input  procPkg::exMemT exMem,
   input  procPkg::hostReqT host,
   output logic [procPkg::dataWidth-1:0] hostRdata,
   output procPkg::memWbT memWb
);
   import procPkg::*;

   logic [dataWidth-1:0] dmem [memDepth];
   logic [addrWidth-1:0] addr;
   logic [dataWidth-1:0] wdata;
   logic [dataWidth-1:0] rdata;
   logic we;
   logic kill;
   memWbT nxt;

   // a halt in writeback squashes the instruction behind it
   assign kill = memWb.valid && memWb.halt;

   // the host owns the port whenever the core is stopped
   assign addr = run ? exMem.result[addrWidth-1:0] : host.addr;
   assign wdata = run ? exMem.storeData : host.wdata;
   assign we = run ? (exMem.valid && exMem.memWrite && !kill) : host.dmemWe;

   always_ff @(posedge clk) begin
      if (we) begin
         dmem[addr] <= wdata;
      end
   end

   assign rdata = dmem[addr];
   assign hostRdata = rdata;

   always_comb begin
      nxt.valid = run && exMem.valid && !kill;
      nxt.rd = exMem.rd;
      nxt.wbData = exMem.memRead ? rdata : exMem.result;
      nxt.regWrite = exMem.regWrite;
      nxt.halt = exMem.halt;
      nxt.err = exMem.halt && exMem.result[0];
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         memWb <= '0;
      end else begin
         memWb <= nxt;
      end
   end

endmodule

/* src/proc.sv */
module proc (
   input  logic clk,
   input  logic rstN,
   input  logic [11:0] paddr,
   input  logic psel,
   input  logic penable,
   input  logic pwrite,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata,
   output logic pready,
   output logic pslverr
);
   import procPkg::*;

   hostReqT host;
   logic [dataWidth-1:0] hostRdata;
   logic run;
   logic start;
   logic stall;
   logic redirect;
   logic [addrWidth-1:0] target;
   ifIdT ifId;
   idExT idEx;
   exMemT exMem;
   memWbT memWb;

   fetchStage fetch_i (
      .clk(clk),
      .rstN(rstN),
      .run(run),
      .start(start),
      .host(host),
      .stall(stall),
      .redirect(redirect),
      .target(target),
      .ifId(ifId)
   );

   // a redirect also flushes the instruction sitting in decode
   decodeStage decode_i (
      .clk(clk),
      .rstN(rstN),
      .run(run),
      .ifId(ifId),
      .memWb(memWb),
      .flush(redirect),
      .stall(stall),
      .idEx(idEx)
   );

   executeStage execute_i (
      .clk(clk),
      .rstN(rstN),
      .run(run),
      .idEx(idEx),
      .exMem(exMem),
      .memWb(memWb),
      .redirect(redirect),
      .target(target)
   );

   memoryStage memory_i (
      .clk(clk),
      .rstN(rstN),
      .run(run),
      .exMem(exMem),
      .host(host),
      .hostRdata(hostRdata),
      .memWb(memWb)
   );

   apbHost host_i (
      .clk(clk),
      .rstN(rstN),
      .paddr(paddr),
      .psel(psel),
      .penable(penable),
      .pwrite(pwrite),
      .pwdata(pwdata),
      .prdata(prdata),
      .pready(pready),
      .pslverr(pslverr),
      .memWb(memWb),
      .hostRdata(hostRdata),
      .host(host),
      .run(run),
      .start(start)
   );

endmodule

/* src/procPkg.sv */
package procPkg;

   localparam int dataWidth = 16;
   localparam int memDepth = 256;
   localparam int addrWidth = $clog2(memDepth);
   localparam int regAddrWidth = 3;

   // APB byte addresses, each memory window spans 1 KB
   localparam logic [11:0] ctrlAddr = 12'h000;
   localparam logic [11:0] statusAddr = 12'h004;
   localparam logic [11:0] imemBase = 12'h400;
   localparam logic [11:0] dmemBase = 12'h800;

   // codes 9 to 14 are illegal
   typedef enum logic [3:0] {
      opAdd  = 4'd0,
      opSub  = 4'd1,
      opAnd  = 4'd2,
      opXor  = 4'd3,
      opAddi = 4'd4,
      opLbi  = 4'd5,
      opLd   = 4'd6,
      opSt   = 4'd7,
      opBeqz = 4'd8,
      opHalt = 4'd15
   } opcodeT;

   typedef struct packed {
      opcodeT opcode;
      logic [regAddrWidth-1:0] rd;
      logic [regAddrWidth-1:0] rs;
      logic [regAddrWidth-1:0] rt;
      logic [2:0] spare;
   } rTypeT;

   typedef struct packed {
      opcodeT opcode;
      logic [regAddrWidth-1:0] rd;
      logic [regAddrWidth-1:0] rs;
      logic signed [5:0] imm;
   } iTypeT;

   typedef struct packed {
      opcodeT opcode;
      logic [regAddrWidth-1:0] rd;
      logic signed [8:0] imm;
   } lTypeT;

   // one instruction word, three ways to read its fields
   typedef union packed {
      rTypeT rType;
      iTypeT iType;
      lTypeT lType;
   } instrT;

   typedef struct packed {
      logic valid;
      logic [addrWidth-1:0] pc;
      instrT instr;
   } ifIdT;

   typedef struct packed {
      logic valid;
      opcodeT op;
      logic [regAddrWidth-1:0] rd;
      logic [regAddrWidth-1:0] rs;
      logic [regAddrWidth-1:0] rt;
      logic [dataWidth-1:0] srcA;
      logic [dataWidth-1:0] srcB;
      logic [dataWidth-1:0] imm;
      logic regWrite;
      logic memRead;
      logic memWrite;
      logic branch;
      logic halt;
      logic [addrWidth-1:0] pc;
   } idExT;

   typedef struct packed {
      logic valid;
      logic [regAddrWidth-1:0] rd;
      logic [dataWidth-1:0] result;
      logic [dataWidth-1:0] storeData;
      logic regWrite;
      logic memRead;
      logic memWrite;
      logic halt;
   } exMemT;

   typedef struct packed {
      logic valid;
      logic [regAddrWidth-1:0] rd;
      logic [dataWidth-1:0] wbData;
      logic regWrite;
      logic halt;
      logic err;
   } memWbT;

   typedef struct packed {
      logic [addrWidth-1:0] addr;
      logic [dataWidth-1:0] wdata;
      logic imemWe;
      logic dmemWe;
   } hostReqT;

endpackage

/* verification/procTb.sv */
module procTb;
   timeunit 1ns;
   timeprecision 1ps;
   import procPkg::*;

   localparam int clkPeriod = 20;
   localparam int testCount = 6;
   localparam int cyclesPerTest = 400;
   // reset and some slack on top of the longest tests
   localparam int maxCycles = testCount * cyclesPerTest + 100;
   localparam int checkWords = 16;
   localparam int padWords = 4;
   localparam int modelSteps = 200;

   logic clk;
   logic rstN;
   logic [11:0] paddr;
   logic psel;
   logic penable;
   logic pwrite;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic pready;
   logic pslverr;

   // expectations for the APB access in flight
   logic expErr;
   logic checkData;
   logic [31:0] expData;

   int errors;
   int errorsBefore;
   int testsRun;
   int testsFailed;
   int cycleCount;
   logic [31:0] lfsrState;
   logic [15:0] prog[$];
   logic [15:0] modelRegs [8];
   logic [15:0] modelMem [256];
   logic modelErr;

   proc proc_i (
      .clk(clk),
      .rstN(rstN),
      .paddr(paddr),
      .psel(psel),
      .penable(penable),
      .pwrite(pwrite),
      .pwdata(pwdata),
      .prdata(prdata),
      .pready(pready),
      .pslverr(pslverr)
   );

   initial begin
      clk = 1'b0;
      forever #(clkPeriod / 2) clk = ~clk;
   end

   initial begin
      cycleCount = 0;
      while (cycleCount < maxCycles) begin
         @(posedge clk);
         cycleCount = cycleCount + 1;
      end
      $display("timeout, the run did not finish within %0d cycles", maxCycles);
      $display("TESTS FAILED");
      $finish;
   end

   assert property (@(posedge clk) disable iff (!rstN) psel && penable |-> pslverr == expErr)
      else begin
         $display("CHECK FAILED at %0t: pslverr is %0b, expected %0b",
                  $time, $sampled(pslverr), $sampled(expErr));
         errors = errors + 1;
      end

   assert property (@(posedge clk) disable iff (!rstN)
      psel && penable && checkData |-> prdata == expData)
      else begin
         $display("CHECK FAILED at %0t: prdata is %h, expected %h",
                  $time, $sampled(prdata), $sampled(expData));
         errors = errors + 1;
      end

   assert property (@(posedge clk) disable iff (!rstN) psel && penable |-> pready)
      else begin
         $display("pready was low in an APB access cycle at %0t", $time);
         errors = errors + 1;
      end

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsrStep(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] randBits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsrState = lfsrStep(lfsrState);
         v = {v[30:0], lfsrState[0]};
      end
      return v;
   endfunction

   function automatic logic [15:0] encR(input logic [3:0] op, input logic [2:0] rd,
                                        input logic [2:0] rs, input logic [2:0] rt);
      return {op, rd, rs, rt, 3'b000};
   endfunction

   function automatic logic [15:0] encI(input logic [3:0] op, input logic [2:0] rd,
                                        input logic [2:0] rs, input logic [5:0] imm);
      return {op, rd, rs, imm};
   endfunction

   function automatic logic [15:0] encL(input logic [3:0] op, input logic [2:0] rd,
                                        input logic [8:0] imm);
      return {op, rd, imm};
   endfunction

   function automatic logic [11:0] dmemAddr(input logic [7:0] a);
      return dmemBase + {2'b00, a, 2'b00};
   endfunction

   function automatic logic [11:0] imemAddr(input logic [7:0] a);
      return imemBase + {2'b00, a, 2'b00};
   endfunction

   function automatic logic [15:0] fillWord(input logic [7:0] a);
      return {a ^ 8'h5a, ~a};
   endfunction

   // called on a falling edge, returns on the falling edge after the access
   task automatic apbWrite(input logic [11:0] addr, input logic [31:0] data, input logic err);
      paddr = addr;
      pwdata = data;
      pwrite = 1'b1;
      psel = 1'b1;
      penable = 1'b0;
      expErr = err;
      checkData = 1'b0;
      @(negedge clk);
      penable = 1'b1;
      @(negedge clk);
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
   endtask

   task automatic apbRead(input logic [11:0] addr, input logic chk, input logic [31:0] exp,
                          input logic err, output logic [31:0] data);
      paddr = addr;
      pwrite = 1'b0;
      psel = 1'b1;
      penable = 1'b0;
      expErr = err;
      checkData = chk;
      expData = exp;
      @(negedge clk);
      penable = 1'b1;
      @(negedge clk);
      data = prdata;
      psel = 1'b0;
      penable = 1'b0;
      checkData = 1'b0;
   endtask

   // reference interpreter, one instruction per step in program order
   task automatic modelRun();
      int pc;
      int steps;
      logic [15:0] w;
      logic [15:0] imm6;
      logic [15:0] imm9;
      logic [7:0] ea;
      logic done;
      pc = 0;
      steps = 0;
      done = 1'b0;
      modelErr = 1'b0;
      while (!done && steps < modelSteps) begin
         // past the end sits the halt padding
         w = (pc < prog.size()) ? prog[pc] : 16'hf000;
         imm6 = {{10{w[5]}}, w[5:0]};
         imm9 = {{7{w[8]}}, w[8:0]};
         ea = 8'(modelRegs[w[8:6]] + imm6);
         pc = pc + 1;
         steps = steps + 1;
         case (w[15:12])
            opAdd: modelRegs[w[11:9]] = modelRegs[w[8:6]] + modelRegs[w[5:3]];
            opSub: modelRegs[w[11:9]] = modelRegs[w[8:6]] - modelRegs[w[5:3]];
            opAnd: modelRegs[w[11:9]] = modelRegs[w[8:6]] & modelRegs[w[5:3]];
            opXor: modelRegs[w[11:9]] = modelRegs[w[8:6]] ^ modelRegs[w[5:3]];
            opAddi: modelRegs[w[11:9]] = modelRegs[w[8:6]] + imm6;
            opLbi: modelRegs[w[11:9]] = imm9;
            opLd: modelRegs[w[11:9]] = modelMem[ea];
            opSt: modelMem[ea] = modelRegs[w[11:9]];
            opBeqz: begin
               if (modelRegs[w[11:9]] == '0) begin
                  pc = (pc + int'($signed(imm9))) & 255;
               end
            end
            opHalt: done = 1'b1;
            default: begin
               done = 1'b1;
               modelErr = 1'b1;
            end
         endcase
      end
   endtask

   task automatic loadProgram();
      for (int a = 0; a < checkWords; a++) begin
         modelMem[a] = fillWord(8'(a));
         apbWrite(dmemAddr(8'(a)), {16'h0000, modelMem[a]}, 1'b0);
      end
      for (int i = 0; i < prog.size(); i++) begin
         apbWrite(imemAddr(8'(i)), {16'h0000, prog[i]}, 1'b0);
      end
      // words fetched behind the last instruction must decode cleanly
      for (int i = 0; i < padWords; i++) begin
         apbWrite(imemAddr(8'(prog.size() + i)), 32'h0000_f000, 1'b0);
      end
      modelRun();
   endtask

   task automatic startCore();
      apbWrite(ctrlAddr, 32'h1, 1'b0);
   endtask

   task automatic waitHalted();
      logic [31:0] data;
      data = '0;
      while (!data[1]) begin
         apbRead(statusAddr, 1'b0, '0, 1'b0, data);
      end
      apbRead(statusAddr, 1'b1, {29'b0, modelErr, 2'b10}, 1'b0, data);
   endtask

   task automatic checkDmem();
      logic [31:0] data;
      for (int a = 0; a < checkWords; a++) begin
         apbRead(dmemAddr(8'(a)), 1'b1, {16'h0000, modelMem[a]}, 1'b0, data);
      end
   endtask

   task automatic runProgram();
      loadProgram();
      startCore();
      waitHalted();
      checkDmem();
   endtask

   task automatic endTest(input string name);
      testsRun = testsRun + 1;
      if (errors == errorsBefore) begin
         $display("test %0d, %s: ok", testsRun, name);
      end else begin
         testsFailed = testsFailed + 1;
         $display("test %0d, %s: %0d checks failed", testsRun, name, errors - errorsBefore);
      end
      errorsBefore = errors;
   endtask

   task automatic testReset();
      logic [31:0] data;
      apbRead(statusAddr, 1'b1, 32'h0, 1'b0, data);
      apbRead(12'h100, 1'b0, '0, 1'b1, data);
      apbWrite(12'hc00, 32'h1, 1'b1);
      apbWrite(dmemAddr(8'd7), 32'hffff_1234, 1'b0);
      apbRead(dmemAddr(8'd7), 1'b1, 32'h0000_1234, 1'b0, data);
      // imem is write only
      apbRead(imemAddr(8'd0), 1'b1, 32'h0, 1'b0, data);
      endTest("reset and register map");
   endtask

   task automatic testForwarding();
      prog.delete();
      prog.push_back(encL(opLbi, 3'd0, 9'd0));
      prog.push_back(encL(opLbi, 3'd1, 9'(-100)));
      prog.push_back(encR(opAdd, 3'd2, 3'd1, 3'd1));
      prog.push_back(encR(opSub, 3'd3, 3'd2, 3'd1));
      prog.push_back(encR(opAnd, 3'd4, 3'd3, 3'd2));
      prog.push_back(encR(opXor, 3'd5, 3'd4, 3'd3));
      prog.push_back(encI(opAddi, 3'd6, 3'd5, 6'(-7)));
      for (int r = 1; r <= 6; r++) begin
         prog.push_back(encI(opSt, 3'(r), 3'd0, 6'(r - 1)));
      end
      prog.push_back(16'hf000);
      runProgram();
      endTest("forwarding");
   endtask

   task automatic testLoadUse();
      prog.delete();
      prog.push_back(encL(opLbi, 3'd0, 9'd0));
      prog.push_back(encL(opLbi, 3'd1, 9'd100));
      prog.push_back(encL(opLbi, 3'd2, 9'(-3)));
      prog.push_back(encI(opSt, 3'd1, 3'd0, 6'd6));
      prog.push_back(encI(opLd, 3'd3, 3'd0, 6'd6));
      prog.push_back(encR(opAdd, 3'd4, 3'd3, 3'd2));
      prog.push_back(encI(opSt, 3'd4, 3'd0, 6'd7));
      prog.push_back(16'hf000);
      runProgram();
      endTest("load-use");
   endtask

   task automatic testBranch();
      prog.delete();
      prog.push_back(encL(opLbi, 3'd1, 9'd9));
      prog.push_back(encL(opLbi, 3'd0, 9'd0));
      // taken, the two marker stores are skipped
      prog.push_back(encL(opBeqz, 3'd0, 9'd2));
      prog.push_back(encI(opSt, 3'd1, 3'd0, 6'd1));
      prog.push_back(encI(opSt, 3'd1, 3'd0, 6'd2));
      prog.push_back(encL(opBeqz, 3'd1, 9'd1));
      prog.push_back(encI(opSt, 3'd1, 3'd0, 6'd3));
      prog.push_back(16'hf000);
      runProgram();
      endTest("branches");
   endtask

   task automatic testRandom();
      logic [2:0] sel;
      logic [2:0] rd;
      logic [2:0] rs;
      logic [2:0] rt;
      prog.delete();
      prog.push_back(encL(opLbi, 3'd0, 9'd0));
      for (int r = 1; r <= 4; r++) begin
         prog.push_back(encL(opLbi, 3'(r), 9'(randBits(9))));
      end
      for (int i = 0; i < 8; i++) begin
         sel = 3'(randBits(3));
         rd = 3'(randBits(2)) + 3'd1;
         rs = 3'(randBits(2)) + 3'd1;
         rt = 3'(randBits(2)) + 3'd1;
         if (sel < 3'd4) begin
            prog.push_back(encR({1'b0, sel}, rd, rs, rt));
         end else begin
            prog.push_back(encI(opAddi, rd, rs, 6'(randBits(6))));
         end
      end
      for (int r = 1; r <= 4; r++) begin
         prog.push_back(encI(opSt, 3'(r), 3'd0, 6'(7 + r)));
      end
      prog.push_back(16'hf000);
      runProgram();
      endTest("random arithmetic");
   endtask

   task automatic testIllegal();
      logic [31:0] data;
      prog.delete();
      prog.push_back(encL(opLbi, 3'd2, 9'd0));
      prog.push_back(encL(opLbi, 3'd1, 9'h055));
      prog.push_back(encI(opSt, 3'd1, 3'd2, 6'd3));
      prog.push_back(16'h9000);
      prog.push_back(encI(opSt, 3'd1, 3'd2, 6'd4));
      prog.push_back(16'hf000);
      loadProgram();
      startCore();
      // the core is still busy for several cycles after start
      apbRead(dmemAddr(8'd0), 1'b0, '0, 1'b1, data);
      apbWrite(dmemAddr(8'd5), 32'h0000_0bad, 1'b1);
      waitHalted();
      checkDmem();
      endTest("illegal opcode and access while running");
   endtask

   initial begin
      rstN = 1'b0;
      paddr = '0;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      pwdata = '0;
      expErr = 1'b0;
      checkData = 1'b0;
      expData = '0;
      errors = 0;
      errorsBefore = 0;
      testsRun = 0;
      testsFailed = 0;
      lfsrState = 32'h87eb_cb1a;
      foreach (modelRegs[i]) begin
         modelRegs[i] = '0;
      end
      repeat (4) @(posedge clk);
      @(negedge clk);
      rstN = 1'b1;
      testReset();
      testForwarding();
      testLoadUse();
      testBranch();
      testRandom();
      testIllegal();
      $display("%0d tests run, %0d failed, %0d checks failed", testsRun, testsFailed, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule
